// ==== hw/spi_pkg.sv ====
package spi_pkg;

  // Wire mode, mode 0 out of reset
  localparam logic CPOL = 1'b0;  // SCLK idle level
  localparam logic CPHA = 1'b0;  // 0 samples on leading edge, 1 on trailing edge

  localparam int FRAME_BITS = 8;  // Bits per frame, MSB first
  localparam int FIFO_DEPTH = 4;  // Entries in each FIFO

  localparam int CNT_W   = $clog2(FRAME_BITS);      // Bit counter width
  localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);  // Holds 0 to FIFO_DEPTH

  // One frame on the wire, tx FIFO entry
  typedef logic [FRAME_BITS-1:0] spi_byte_t;

  // Rx FIFO entry, bit order matches RXDATA
  typedef struct packed {
    logic      tx_underrun;  // No tx byte was ready for this frame
    spi_byte_t data;
  } rx_entry_t;

  // Synchronized pin view
  typedef struct packed {
    logic sample;     // Capture COPI now
    logic shift;      // Advance CIPO now
    logic cs_fall;    // Frame burst begins
    logic cs_rise;    // Frame burst ends
    logic cs_active;  // CS held low
    logic copi;       // Synced data in
  } spi_strobe_t;

  // Error events, same order as STATUS bits 4:2
  typedef struct packed {
    logic overrun;   // Rx entry dropped, FIFO full
    logic underrun;  // Frame sent without a tx byte
    logic abort;     // CS rose mid frame
  } spi_flags_t;

endpackage

// ==== hw/axil_pkg.sv ====
package axil_pkg;

  localparam int ADDR_W = 4;
  localparam int DATA_W = 32;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_t;

  // Host to target
  typedef struct packed {
    logic [ADDR_W-1:0]   awaddr;
    logic                awvalid;
    logic [DATA_W-1:0]   wdata;
    logic [DATA_W/8-1:0] wstrb;  // Accepted, full word writes only
    logic                wvalid;
    logic                bready;
    logic [ADDR_W-1:0]   araddr;
    logic                arvalid;
    logic                rready;
  } axil_req_t;

  // Target to host
  typedef struct packed {
    logic              awready;
    logic              wready;
    axil_resp_t        bresp;
    logic              bvalid;
    logic              arready;
    logic [DATA_W-1:0] rdata;
    axil_resp_t        rresp;
    logic              rvalid;
  } axil_rsp_t;

  // Register map
  localparam logic [ADDR_W-1:0] REG_TXDATA  = 4'h0;  // Write pushes tx FIFO
  localparam logic [ADDR_W-1:0] REG_RXDATA  = 4'h4;  // Read pops rx FIFO
  localparam logic [ADDR_W-1:0] REG_STATUS  = 4'h8;
  localparam logic [ADDR_W-1:0] REG_FLAGCLR = 4'hC;  // Write 1 to clear

  // STATUS fields, flags share their position with FLAGCLR
  localparam int STAT_RX_EMPTY  = 0;
  localparam int STAT_TX_FULL   = 1;
  localparam int STAT_FLAG_LSB  = 2;
  localparam int STAT_RXLVL_LSB = 8;
  localparam int STAT_TXLVL_LSB = 16;

endpackage

// ==== hw/spi_pin_sync.sv ====
`timescale 1ns/1ps
module spi_pin_sync (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sclk,
  input  logic                 cs,
  input  logic                 copi,
  output spi_pkg::spi_strobe_t strobe
);

  logic [2:0] sclk_sync;  // Bit 0 faces the pin
  logic [2:0] cs_sync;
  logic [2:0] copi_sync;
  logic       sclk_q;     // Previous synced SCLK
  logic       cs_q;       // Previous synced CS
  logic       lead_edge;
  logic       trail_edge;
  logic       cs_low;

  // Idle levels out of reset so no false edge at release
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_sync <= {3{spi_pkg::CPOL}};
      cs_sync   <= 3'b111;
      copi_sync <= 3'b000;
      sclk_q    <= spi_pkg::CPOL;
      cs_q      <= 1'b1;
    end else begin
      sclk_sync <= {sclk_sync[1:0], sclk};
      cs_sync   <= {cs_sync[1:0], cs};
      copi_sync <= {copi_sync[1:0], copi};
      sclk_q    <= sclk_sync[2];
      cs_q      <= cs_sync[2];
    end
  end

  // Leading edge leaves the idle level, trailing edge returns to it
  assign lead_edge  = (sclk_q == spi_pkg::CPOL) && (sclk_sync[2] != spi_pkg::CPOL);
  assign trail_edge = (sclk_q != spi_pkg::CPOL) && (sclk_sync[2] == spi_pkg::CPOL);
  assign cs_low     = !cs_sync[2];

  always_comb begin
    strobe.sample    = cs_low && (spi_pkg::CPHA ? trail_edge : lead_edge);
    strobe.shift     = cs_low && (spi_pkg::CPHA ? lead_edge : trail_edge);
    strobe.cs_fall   = cs_q && !cs_sync[2];
    strobe.cs_rise   = !cs_q && cs_sync[2];
    strobe.cs_active = cs_low;
    strobe.copi      = copi_sync[2];  // Aligned with the SCLK stage
  end

endmodule

// ==== hw/spi_frame_engine.sv ====
`timescale 1ns/1ps
module spi_frame_engine (
  input  logic                 clk,
  input  logic                 rst_n,
  input  spi_pkg::spi_strobe_t strobe,
  input  spi_pkg::spi_byte_t   tx_data,   // Tx FIFO head
  input  logic                 tx_empty,
  output logic                 tx_pop,
  input  logic                 rx_full,
  output logic                 rx_push,
  output spi_pkg::rx_entry_t   rx_entry,
  output spi_pkg::spi_flags_t  events,    // One-cycle pulses
  output logic                 cipo
);

  spi_pkg::spi_byte_t        tx_sr;           // MSB is on CIPO
  spi_pkg::spi_byte_t        rx_sr;
  logic [spi_pkg::CNT_W-1:0] bit_cnt;         // Bits sampled in this frame
  logic                      frame_underrun;  // Frame carries the 0x00 fill
  logic                      skip_shift;      // Next shift strobe belongs to no bit
  logic                      frame_done;      // Last bit sampled one clk ago
  logic                      first_bit;
  logic                      last_bit;
  logic                      load;
  logic                      shift_now;
  spi_pkg::spi_byte_t        load_byte;

  assign first_bit = strobe.sample && (bit_cnt == '0);
  assign last_bit  = strobe.sample && (bit_cnt == (spi_pkg::FRAME_BITS - 1));
  assign load      = strobe.cs_fall || last_bit;  // Frame start
  assign shift_now = strobe.shift && !skip_shift;
  assign load_byte = tx_empty ? '0 : tx_data;

  // Head is only peeked at load
  // Pop commits on the first sample so an unclocked frame keeps its byte
  assign tx_pop  = first_bit && !frame_underrun;
  assign rx_push = frame_done && !rx_full;

  always_comb begin
    events.overrun  = frame_done && rx_full;      // Entry dropped
    events.underrun = first_bit && frame_underrun;
    events.abort    = strobe.cs_rise && (bit_cnt != '0);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt        <= '0;
      frame_underrun <= 1'b0;
      skip_shift     <= 1'b0;
      frame_done     <= 1'b0;
      cipo           <= 1'b0;
    end else begin
      frame_done <= last_bit;
      if (strobe.cs_rise || last_bit) begin
        bit_cnt <= '0;  // Partial frame discarded on cs_rise
      end else if (strobe.sample) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      if (load) begin
        frame_underrun <= tx_empty;
        // CPHA 1 starts every frame with a dead leading shift
        // CPHA 0 has one after the last sample of a frame
        skip_shift     <= spi_pkg::CPHA || !strobe.cs_fall;
      end else if (strobe.shift) begin
        skip_shift <= 1'b0;
      end
      if (!strobe.cs_active) begin
        cipo <= 1'b0;  // Low while deselected
      end else if (load) begin
        cipo <= load_byte[spi_pkg::FRAME_BITS-1];
      end else if (shift_now) begin
        cipo <= tx_sr[spi_pkg::FRAME_BITS-2];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      tx_sr <= load_byte;
    end else if (shift_now) begin
      tx_sr <= {tx_sr[spi_pkg::FRAME_BITS-2:0], 1'b0};
    end
    if (strobe.sample) begin
      rx_sr <= {rx_sr[spi_pkg::FRAME_BITS-2:0], strobe.copi};
    end
    if (last_bit) begin
      rx_entry.data        <= {rx_sr[spi_pkg::FRAME_BITS-2:0], strobe.copi};
      rx_entry.tx_underrun <= frame_underrun;
    end
  end

  a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
    bit_cnt < spi_pkg::FRAME_BITS);

  // Tx FIFO flags come from another module
  a_pop_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
    tx_pop |-> !tx_empty);

endmodule

// ==== hw/spi_byte_fifo.sv ====
`timescale 1ns/1ps
module spi_byte_fifo #(
  parameter type entry_t = logic [7:0],
  parameter int  DEPTH   = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       push,
  input  entry_t                     push_data,
  input  logic                       pop,
  output entry_t                     pop_data,  // Head, valid while not empty
  output logic                       empty,
  output logic                       full,
  output logic [$clog2(DEPTH+1)-1:0] level
);

  entry_t                     mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic                       wr_en;
  logic                       rd_en;

  assign wr_en = push && !full;
  assign rd_en = pop && !empty;

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (wr_en) wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;  // Any depth wraps
      if (rd_en) rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;  // Idle or push with pop
      endcase
    end
  end

  assign empty    = (level == '0);
  assign full     = (level == DEPTH);
  assign pop_data = mem[rd_ptr];  // Fall-through head

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !full);

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> !empty);

endmodule

// ==== hw/spi_csr.sv ====
`timescale 1ns/1ps
module spi_csr (
  input  logic                        clk,
  input  logic                        rst_n,
  input  axil_pkg::axil_req_t         axil_req,
  output axil_pkg::axil_rsp_t         axil_rsp,
  output logic                        tx_push,
  output spi_pkg::spi_byte_t          tx_wdata,
  input  logic                        tx_full,
  input  logic [spi_pkg::LEVEL_W-1:0] tx_level,
  output logic                        rx_pop,
  input  spi_pkg::rx_entry_t          rx_head,
  input  logic                        rx_empty,
  input  logic [spi_pkg::LEVEL_W-1:0] rx_level,
  input  spi_pkg::spi_flags_t         events
);

  logic                        wr_hs;    // Address and data taken together
  logic                        rd_hs;
  logic                        bvalid;
  logic                        rvalid;
  axil_pkg::axil_resp_t        bresp;
  axil_pkg::axil_resp_t        rresp;
  axil_pkg::axil_resp_t        wr_resp;
  axil_pkg::axil_resp_t        rd_resp;
  logic [axil_pkg::DATA_W-1:0] rdata;
  logic [axil_pkg::DATA_W-1:0] rd_word;  // Decoded in the handshake cycle
  logic [axil_pkg::DATA_W-1:0] status;
  spi_pkg::spi_flags_t         flags;    // Sticky copy of events
  spi_pkg::spi_flags_t         flag_clr;

  assign wr_hs = axil_req.awvalid && axil_req.wvalid && !bvalid;
  assign rd_hs = axil_req.arvalid && !rvalid;

  // Full tx FIFO drops the byte
  assign tx_wdata = axil_req.wdata[spi_pkg::FRAME_BITS-1:0];
  assign tx_push  = wr_hs && (axil_req.awaddr == axil_pkg::REG_TXDATA) && !tx_full;
  assign wr_resp  = ((axil_req.awaddr == axil_pkg::REG_TXDATA) && tx_full) ?
                    axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
  assign rx_pop   = rd_hs && (axil_req.araddr == axil_pkg::REG_RXDATA) && !rx_empty;
  assign flag_clr = (wr_hs && (axil_req.awaddr == axil_pkg::REG_FLAGCLR)) ?
                    axil_req.wdata[axil_pkg::STAT_FLAG_LSB +: $bits(spi_pkg::spi_flags_t)] : '0;

  always_comb begin
    status = '0;
    status[axil_pkg::STAT_RX_EMPTY] = rx_empty;
    status[axil_pkg::STAT_TX_FULL]  = tx_full;
    status[axil_pkg::STAT_FLAG_LSB +: $bits(spi_pkg::spi_flags_t)] = flags;
    status[axil_pkg::STAT_RXLVL_LSB +: spi_pkg::LEVEL_W] = rx_level;
    status[axil_pkg::STAT_TXLVL_LSB +: spi_pkg::LEVEL_W] = tx_level;
  end

  always_comb begin
    rd_word = '0;
    rd_resp = axil_pkg::RESP_OKAY;
    case (axil_req.araddr)
      axil_pkg::REG_RXDATA: begin
        if (rx_empty) rd_resp = axil_pkg::RESP_SLVERR;  // Nothing to pop, data 0
        else rd_word[$bits(spi_pkg::rx_entry_t)-1:0] = rx_head;
      end
      axil_pkg::REG_STATUS: rd_word = status;
      axil_pkg::REG_TXDATA, axil_pkg::REG_FLAGCLR: rd_word = '0;  // Write-only
      default: rd_resp = axil_pkg::RESP_SLVERR;  // Unmapped
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      flags  <= '0;
    end else begin
      if (wr_hs) bvalid <= 1'b1;
      else if (axil_req.bready) bvalid <= 1'b0;
      if (rd_hs) rvalid <= 1'b1;
      else if (axil_req.rready) rvalid <= 1'b0;
      flags <= (flags & ~flag_clr) | events;  // New event beats a clear
    end
  end

  // Held until the next handshake
  always_ff @(posedge clk) begin
    if (wr_hs) bresp <= wr_resp;
    if (rd_hs) begin
      rdata <= rd_word;
      rresp <= rd_resp;
    end
  end

  always_comb begin
    axil_rsp.awready = wr_hs;
    axil_rsp.wready  = wr_hs;
    axil_rsp.bresp   = bresp;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.arready = !rvalid;  // One read in flight
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = rresp;
    axil_rsp.rvalid  = rvalid;
  end

  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !axil_req.bready |=> bvalid && $stable(bresp));

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !axil_req.rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// ==== hw/spi_target_top.sv ====
`timescale 1ns/1ps
module spi_target_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                sclk,
  input  logic                cs,        // Active low
  input  logic                copi,
  output logic                cipo,
  input  axil_pkg::axil_req_t axil_req,
  output axil_pkg::axil_rsp_t axil_rsp
);

  spi_pkg::spi_strobe_t        strobe;
  spi_pkg::spi_byte_t          tx_head;   // Next byte for the wire
  spi_pkg::spi_byte_t          tx_wdata;  // Byte from the host
  logic                        tx_push;
  logic                        tx_pop;
  logic                        tx_empty;
  logic                        tx_full;
  logic [spi_pkg::LEVEL_W-1:0] tx_level;
  spi_pkg::rx_entry_t          rx_entry;  // Frame just received
  spi_pkg::rx_entry_t          rx_head;   // Oldest frame for the host
  logic                        rx_push;
  logic                        rx_pop;
  logic                        rx_empty;
  logic                        rx_full;
  logic [spi_pkg::LEVEL_W-1:0] rx_level;
  spi_pkg::spi_flags_t         events;

  spi_pin_sync u_pin_sync (
    .clk    (clk),
    .rst_n  (rst_n),
    .sclk   (sclk),
    .cs     (cs),
    .copi   (copi),
    .strobe (strobe)
  );

  spi_frame_engine u_frame_engine (
    .clk      (clk),
    .rst_n    (rst_n),
    .strobe   (strobe),
    .tx_data  (tx_head),
    .tx_empty (tx_empty),
    .tx_pop   (tx_pop),
    .rx_full  (rx_full),
    .rx_push  (rx_push),
    .rx_entry (rx_entry),
    .events   (events),
    .cipo     (cipo)
  );

  spi_byte_fifo #(
    .entry_t (spi_pkg::spi_byte_t),
    .DEPTH   (spi_pkg::FIFO_DEPTH)
  ) u_tx_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (tx_push),
    .push_data (tx_wdata),
    .pop       (tx_pop),
    .pop_data  (tx_head),
    .empty     (tx_empty),
    .full      (tx_full),
    .level     (tx_level)
  );

  spi_byte_fifo #(
    .entry_t (spi_pkg::rx_entry_t),
    .DEPTH   (spi_pkg::FIFO_DEPTH)
  ) u_rx_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (rx_push),
    .push_data (rx_entry),
    .pop       (rx_pop),
    .pop_data  (rx_head),
    .empty     (rx_empty),
    .full      (rx_full),
    .level     (rx_level)
  );

  spi_csr u_csr (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .tx_push  (tx_push),
    .tx_wdata (tx_wdata),
    .tx_full  (tx_full),
    .tx_level (tx_level),
    .rx_pop   (rx_pop),
    .rx_head  (rx_head),
    .rx_empty (rx_empty),
    .rx_level (rx_level),
    .events   (events)
  );

endmodule

// ==== verification/tb_spi_tasks.svh ====
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// Wait n clocks and land just after the edge
task automatic step_clocks(input int n);
  repeat (n) @(posedge clk);
  #1;
endtask

task automatic axil_write(input logic [axil_pkg::ADDR_W-1:0] addr,
                          input logic [axil_pkg::DATA_W-1:0] data,
                          output axil_pkg::axil_resp_t resp);
  int n;
  axil_req.awaddr  = addr;
  axil_req.wdata   = data;
  axil_req.wstrb   = '1;
  axil_req.awvalid = 1'b1;
  axil_req.wvalid  = 1'b1;
  axil_req.bready  = 1'b1;  // Ready for the response up front
  n = 0;
  @(negedge clk);  // Mid cycle with outputs settled
  while (!(axil_rsp.awready && axil_rsp.wready)) begin
    n++;
    if (n > HS_TIMEOUT) timeout_stop("AXI write address and data handshake");
    @(negedge clk);
  end
  @(posedge clk);
  #1;
  axil_req.awvalid = 1'b0;
  axil_req.wvalid  = 1'b0;
  n = 0;
  @(negedge clk);
  while (!axil_rsp.bvalid) begin
    n++;
    if (n > HS_TIMEOUT) timeout_stop("AXI write response");
    @(negedge clk);
  end
  resp = axil_rsp.bresp;
  step_clocks(1);
  axil_req.bready = 1'b0;
endtask

task automatic axil_read(input logic [axil_pkg::ADDR_W-1:0] addr,
                         output logic [axil_pkg::DATA_W-1:0] data,
                         output axil_pkg::axil_resp_t resp);
  int n;
  axil_req.araddr  = addr;
  axil_req.arvalid = 1'b1;
  axil_req.rready  = 1'b1;
  n = 0;
  @(negedge clk);
  while (!axil_rsp.arready) begin
    n++;
    if (n > HS_TIMEOUT) timeout_stop("AXI read address handshake");
    @(negedge clk);
  end
  @(posedge clk);
  #1;
  axil_req.arvalid = 1'b0;  // Single read
  n = 0;
  @(negedge clk);
  while (!axil_rsp.rvalid) begin
    n++;
    if (n > HS_TIMEOUT) timeout_stop("AXI read data");
    @(negedge clk);
  end
  data = axil_rsp.rdata;
  resp = axil_rsp.rresp;
  step_clocks(1);
  axil_req.rready = 1'b0;
endtask

// Controller side of one frame that nbits below FRAME_BITS cuts short
task automatic spi_frame(input spi_pkg::spi_byte_t out_byte, input int nbits,
                         output spi_pkg::spi_byte_t in_byte);
  int i;
  in_byte = '0;
  for (i = spi_pkg::FRAME_BITS - 1; i >= spi_pkg::FRAME_BITS - nbits; i--) begin
    if (!spi_pkg::CPHA) copi = out_byte[i];  // Set up before leading edge
    step_clocks(SCLK_HALF);
    if (!spi_pkg::CPHA) in_byte[i] = cipo;
    sclk = !spi_pkg::CPOL;  // Leading edge
    if (spi_pkg::CPHA) copi = out_byte[i];
    step_clocks(SCLK_HALF);
    if (spi_pkg::CPHA) in_byte[i] = cipo;
    sclk = spi_pkg::CPOL;  // Trailing edge
  end
endtask

task automatic check_rx_entry(input spi_pkg::rx_entry_t got, input spi_pkg::rx_entry_t exp,
                              input string what);
  if (got !== exp) mismatch_stop($sformatf("%s got %h expected %h", what, got, exp));
endtask

task automatic check_cipo(input spi_pkg::spi_byte_t got, input spi_pkg::spi_byte_t exp,
                          input string what);
  if (got !== exp) mismatch_stop($sformatf("%s got %h expected %h", what, got, exp));
endtask

task automatic check_resp(input axil_pkg::axil_resp_t got, input axil_pkg::axil_resp_t exp,
                          input string what);
  if (got !== exp) mismatch_stop($sformatf("%s got %b expected %b", what, got, exp));
endtask

task automatic check_status(input logic [axil_pkg::DATA_W-1:0] got,
                            input logic [axil_pkg::DATA_W-1:0] exp, input string what);
  if (got !== exp) mismatch_stop($sformatf("%s got %h expected %h", what, got, exp));
endtask

`endif

// ==== verification/tb_spi_target.sv ====
`timescale 1ns/1ps
module tb_spi_target;

  localparam int SCLK_HALF    = 8;   // Clocks per SCLK half period
  localparam int HS_TIMEOUT   = 50;  // Clocks per AXI handshake wait
  localparam int STATUS_TRIES = 20;  // STATUS polls before giving up

  logic                clk;
  logic                rst_n;
  logic                sclk;
  logic                cs;
  logic                copi;
  logic                cipo;
  axil_pkg::axil_req_t axil_req;
  axil_pkg::axil_rsp_t axil_rsp;

  // Reference model
  spi_pkg::spi_byte_t  tx_q[$];
  spi_pkg::rx_entry_t  rx_q[$];
  spi_pkg::spi_flags_t flags_m;
  int                  errors = 0;

  spi_target_top u_spi_target_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .sclk     (sclk),
    .cs       (cs),
    .copi     (copi),
    .cipo     (cipo),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  always #5 clk = ~clk;  // 10 ns period

  task automatic mismatch_stop(input string msg);
    errors++;
    $display("Mismatch at time %0t: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic timeout_stop(input string what);
    $display("Timeout at time %0t waiting for %s", $time, what);
    $display("Regression failed");
    $fatal(1, "Stopped on timeout");
  endtask

  `include "tb_spi_tasks.svh"

  // STATUS as the register map defines it
  function automatic logic [axil_pkg::DATA_W-1:0] model_status();
    logic [axil_pkg::DATA_W-1:0] word;
    word        = '0;
    word[0]     = (rx_q.size() == 0);
    word[1]     = (tx_q.size() == spi_pkg::FIFO_DEPTH);
    word[4:2]   = flags_m;  // overrun, underrun, abort
    word[11:8]  = rx_q.size();
    word[19:16] = tx_q.size();
    return word;
  endfunction

  // One full frame and the byte CIPO should carry
  function automatic spi_pkg::spi_byte_t model_frame(input spi_pkg::spi_byte_t copi_byte);
    spi_pkg::rx_entry_t entry;
    spi_pkg::spi_byte_t out;
    entry.tx_underrun = (tx_q.size() == 0);
    out = entry.tx_underrun ? '0 : tx_q.pop_front();
    if (entry.tx_underrun) flags_m.underrun = 1'b1;
    entry.data = copi_byte;
    if (rx_q.size() < spi_pkg::FIFO_DEPTH) rx_q.push_back(entry);
    else flags_m.overrun = 1'b1;  // Entry lost
    return out;
  endfunction

  task automatic push_tx(input spi_pkg::spi_byte_t data);
    axil_pkg::axil_resp_t resp;
    axil_write(axil_pkg::REG_TXDATA, axil_pkg::DATA_W'(data), resp);
    check_resp(resp, axil_pkg::RESP_OKAY, "TXDATA write response");
    tx_q.push_back(data);
  endtask

  task automatic clear_flags(input spi_pkg::spi_flags_t clr);
    axil_pkg::axil_resp_t resp;
    axil_write(axil_pkg::REG_FLAGCLR, axil_pkg::DATA_W'(clr) << 2, resp);
    check_resp(resp, axil_pkg::RESP_OKAY, "FLAGCLR write response");
    flags_m = flags_m & ~clr;
  endtask

  // Poll until STATUS matches the model as pin latency varies
  task automatic settle_status(input string what);
    logic [axil_pkg::DATA_W-1:0] word;
    axil_pkg::axil_resp_t        resp;
    int                          tries;
    tries = 0;
    do begin
      axil_read(axil_pkg::REG_STATUS, word, resp);
      tries++;
    end while (word !== model_status() && tries < STATUS_TRIES);
    check_resp(resp, axil_pkg::RESP_OKAY, {what, " STATUS response"});
    check_status(word, model_status(), what);
  endtask

  // CS-low burst of random COPI bytes
  task automatic spi_burst(input int frames);
    spi_pkg::spi_byte_t out_byte;
    spi_pkg::spi_byte_t got;
    spi_pkg::spi_byte_t exp;
    cs = 1'b0;
    repeat (frames) begin
      out_byte = spi_pkg::spi_byte_t'($urandom);
      exp      = model_frame(out_byte);
      spi_frame(out_byte, spi_pkg::FRAME_BITS, got);
      check_cipo(got, exp, "CIPO byte");
    end
    step_clocks(SCLK_HALF);
    cs = 1'b1;
    step_clocks(SCLK_HALF);
  endtask

  task automatic drain_rx();
    logic [axil_pkg::DATA_W-1:0] word;
    axil_pkg::axil_resp_t        resp;
    while (rx_q.size() > 0) begin
      axil_read(axil_pkg::REG_RXDATA, word, resp);
      check_resp(resp, axil_pkg::RESP_OKAY, "RXDATA read response");
      check_rx_entry(spi_pkg::rx_entry_t'(word[8:0]), rx_q.pop_front(), "RXDATA entry");
    end
  endtask

  initial begin
    logic [axil_pkg::DATA_W-1:0] word;
    axil_pkg::axil_resp_t        resp;
    spi_pkg::spi_byte_t          out_byte;
    spi_pkg::spi_byte_t          got;
    spi_pkg::spi_byte_t          exp;
    spi_pkg::spi_byte_t          mask;
    int                          nbits;
    int                          frames;
    void'($urandom(32'he9ca));
    clk      = 1'b0;
    rst_n    = 1'b0;
    sclk     = spi_pkg::CPOL;  // Bus idle
    cs       = 1'b1;
    copi     = 1'b0;
    axil_req = '0;
    flags_m  = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step_clocks(2);

    // Reset state
    if (cipo !== 1'b0) mismatch_stop("cipo not low after reset");
    settle_status("reset STATUS");

    // Full duplex bursts
    repeat (6) begin
      frames = 1 + $urandom % spi_pkg::FIFO_DEPTH;
      repeat (frames) push_tx(spi_pkg::spi_byte_t'($urandom));
      settle_status("tx level after writes");
      spi_burst(frames);
      settle_status("levels after burst");
      drain_rx();
      settle_status("levels after drain");
    end

    // Underrun with the tx FIFO empty
    spi_burst(1 + $urandom % 2);
    settle_status("underrun flag");
    // STATUS is read-only, flag and levels must hold against an all-ones write
    axil_write(axil_pkg::REG_STATUS, '1, resp);
    check_resp(resp, axil_pkg::RESP_OKAY, "STATUS write");
    axil_read(axil_pkg::REG_STATUS, word, resp);
    check_resp(resp, axil_pkg::RESP_OKAY, "STATUS read after STATUS write");
    check_status(word, model_status(), "STATUS after STATUS write");
    drain_rx();
    clear_flags(3'b010);
    settle_status("underrun cleared");

    // Overrun with one frame more than the rx FIFO holds
    repeat (spi_pkg::FIFO_DEPTH) push_tx(spi_pkg::spi_byte_t'($urandom));
    spi_burst(spi_pkg::FIFO_DEPTH + 1);
    settle_status("overrun flag");
    drain_rx();
    clear_flags(3'b111);
    settle_status("flags cleared after overrun");

    // Abort with one entry already waiting
    push_tx(spi_pkg::spi_byte_t'($urandom));
    spi_burst(1);
    repeat (3) begin
      push_tx(spi_pkg::spi_byte_t'($urandom));
      settle_status("before abort");
      nbits    = 1 + $urandom % (spi_pkg::FRAME_BITS - 1);
      out_byte = spi_pkg::spi_byte_t'($urandom);
      exp      = tx_q.pop_front();  // Consumed at the first bit
      flags_m.abort = 1'b1;
      cs = 1'b0;
      spi_frame(out_byte, nbits, got);
      step_clocks(SCLK_HALF);
      cs = 1'b1;  // Mid frame
      step_clocks(SCLK_HALF);
      mask = '1;
      mask = mask << (spi_pkg::FRAME_BITS - nbits);  // Bits actually clocked
      check_cipo(got & mask, exp & mask, "CIPO before abort");
      settle_status("abort flag, rx level kept");
      clear_flags(3'b001);
    end
    drain_rx();

    // Error responses
    axil_read(axil_pkg::REG_RXDATA, word, resp);
    check_resp(resp, axil_pkg::RESP_SLVERR, "RXDATA read while empty");
    check_status(word, '0, "RXDATA rdata while empty");
    repeat (spi_pkg::FIFO_DEPTH) push_tx(spi_pkg::spi_byte_t'($urandom));
    axil_write(axil_pkg::REG_TXDATA, $urandom, resp);
    check_resp(resp, axil_pkg::RESP_SLVERR, "TXDATA write while full");
    settle_status("tx level stays full");
    axil_read(axil_pkg::ADDR_W'(($urandom % 4) * 4 + 1 + $urandom % 3), word, resp);
    check_resp(resp, axil_pkg::RESP_SLVERR, "unmapped read");
    spi_burst(spi_pkg::FIFO_DEPTH);  // Empties the tx FIFO
    drain_rx();
    settle_status("final STATUS");

    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+verification
hw/spi_pkg.sv
hw/axil_pkg.sv
hw/spi_pin_sync.sv
hw/spi_frame_engine.sv
hw/spi_byte_fifo.sv
hw/spi_csr.sv
hw/spi_target_top.sv
verification/tb_spi_target.sv
